//--- Makefile
# Verilator build and run of the framebuffer testbench

SIM = obj_dir/framebuffer_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f framebuffer_top.f \
		--top-module framebuffer_tb -Mdir obj_dir -o framebuffer_sim

run: compile
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- fb_pkg.sv
package fb_pkg;

    //////////////////////////////////////////////////
    // framebuffer geometry
    localparam int COLOR_BITS    = 18;                      // rgb666
    localparam int CH_BITS       = COLOR_BITS / 3;          // bits per channel
    localparam int MAX_W         = 16;
    localparam int MAX_H         = 8;
    localparam int QUADS_PER_ROW = MAX_W / 4;               // row pitch in quads
    localparam int STORE_DEPTH   = QUADS_PER_ROW * MAX_H;   // 32 quad words
    localparam int ADDR_W        = $clog2(STORE_DEPTH);
    localparam int QX_W          = $clog2(QUADS_PER_ROW);   // quad column bits
    localparam int ROW_W         = $clog2(MAX_H);
    localparam int COL_W         = $clog2(MAX_W);
    localparam int READ_LATENCY  = 2;

    //////////////////////////////////////////////////
    // raster, 64x32 active in 80x40
    localparam int ACTIVE_W      = 64;
    localparam int ACTIVE_H      = 32;
    localparam int H_TOTAL       = 80;
    localparam int V_TOTAL       = 40;
    localparam int H_SYNC_START  = 68;
    localparam int H_SYNC_END    = 72;
    localparam int V_SYNC_START  = 34;
    localparam int V_SYNC_END    = 36;
    localparam int CX_W          = $clog2(H_TOTAL);
    localparam int CY_W          = $clog2(V_TOTAL);
    localparam int COL_ACC_W     = $clog2(ACTIVE_W);        // column accumulator
    localparam int ROW_ACC_W     = $clog2(ACTIVE_H);        // row accumulator
    localparam logic [23:0] BLANK_RGB = 24'h202020;         // grey outside de

    typedef logic [COLOR_BITS-1:0] pixel_t;
    typedef pixel_t [3:0] quad_t;           // pixel 0 in the low bits

    typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ} mem_op_e;
    typedef enum logic [1:0] {FETCH_IDLE, FETCH_ISSUE, FETCH_DRAIN} fetch_state_e;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        quad_t             data;
    } wr_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic  valid;
        quad_t data;
    } rd_rsp_t;

    typedef struct packed {
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        quad_t             data;
    } mem_cmd_t;

    typedef struct packed {
        logic [CX_W-1:0] cx;
        logic [CY_W-1:0] cy;
        logic            active;
        logic            hsync;
        logic            vsync;
    } video_pos_t;

    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hsync;
        logic        vsync;
    } video_out_t;

endpackage

//--- frame_store.sv
`timescale 1ns/1ns

module frame_store (
    input  logic             clk_x1,
    input  logic             rst_n,
    input  fb_pkg::mem_cmd_t mem_cmd,
    output fb_pkg::rd_rsp_t  rd_rsp
);
    import fb_pkg::*;

    quad_t                   mem [STORE_DEPTH];
    logic [READ_LATENCY-1:0] vld_pipe;              // reads in flight
    quad_t                   dat_pipe [READ_LATENCY];

    //////////////////////////////////////////////////
    // array and read data pipe
    always_ff @(posedge clk_x1) begin
        if (mem_cmd.op == OP_WRITE)
            mem[mem_cmd.addr] <= mem_cmd.data;
        dat_pipe[0] <= mem[mem_cmd.addr];   // old data on same address
        for (int i = 1; i < READ_LATENCY; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    always_ff @(posedge clk_x1 or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= (mem_cmd.op == OP_READ);
            for (int i = 1; i < READ_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    assign rd_rsp = '{valid: vld_pipe[READ_LATENCY-1], data: dat_pipe[READ_LATENCY-1]};

endmodule

//--- framebuffer_assertions.sv
`timescale 1ns/1ns

module framebuffer_assertions (
    input logic             clk_x1,
    input logic             rst_n,
    input fb_pkg::wr_req_t  wr_req,
    input logic             wr_grant,
    input logic             rd_grant,
    input fb_pkg::mem_cmd_t mem_cmd,
    input fb_pkg::rd_rsp_t  rd_rsp
);
    import fb_pkg::*;

    logic wr_pending;   // write request not yet served
    logic rd_issued;    // read command on the store port

    assign wr_pending = wr_req.valid && !wr_grant;
    assign rd_issued  = (mem_cmd.op == OP_READ);

    //////////////////////////////////////////////////
    // arbiter side
    grant_exclusive: assert property (@(posedge clk_x1) disable iff (!rst_n)
        !(wr_grant && rd_grant))
        else $error("wr_grant and rd_grant high in the same cycle");

    // writes always win the port
    read_behind_write: assert property (@(posedge clk_x1) disable iff (!rst_n)
        rd_grant |-> !$past(wr_pending))
        else $error("read granted while a write request was pending");

    //////////////////////////////////////////////////
    // frame store side, latency checked both ways
    read_latency: assert property (@(posedge clk_x1) disable iff (!rst_n)
        rd_rsp.valid == $past(rd_issued, READ_LATENCY))
        else $error("rd_rsp.valid not exactly %0d cycles after a read", READ_LATENCY);

endmodule

// watches the arbiter and frame store ports inside the top level
bind framebuffer_top framebuffer_assertions framebuffer_assertions_inst (
    .clk_x1   (clk_x1),
    .rst_n    (rst_n),
    .wr_req   (wr_req),
    .wr_grant (wr_grant),
    .rd_grant (rd_grant),
    .mem_cmd  (mem_cmd),
    .rd_rsp   (rd_rsp)
);

//--- framebuffer_tb.sv
`timescale 1ns/1ns

module framebuffer_tb;
    import fb_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    logic        clk_x1;
    logic        rst_n;
    logic [4:0]  fb_width;
    logic [3:0]  fb_height;
    logic        fb_vsync;
    logic        fb_we;
    pixel_t      fb_data;
    video_out_t  video;

    pixel_t      image [MAX_H][MAX_W];   // what the store should hold
    int          ref_w;                  // size of the compared frame
    int          ref_h;
    logic [7:0]  lfsr;
    int          errors;
    int          passed;
    int          failed;
    int          test_no;
    int          err_mark;               // error count at test start
    int          col_cnt;                // de cycles in this line
    int          line_cnt;               // lines since last vsync
    int          hs_cnt;                 // hsync cycles since last vsync rise
    int          vs_cnt;                 // vsync cycles since last vsync rise
    int          frames_seen;
    int          frame_pixels;
    int          shown;                  // printed rgb mismatches
    logic        de_prev;
    logic        vs_prev;
    logic [23:0] exp_rgb;
    bit          cmp_arm;                // compare the next frame
    bit          cmp_active;
    bit          cmp_done;

    framebuffer_top framebuffer_top_inst (
        .clk_x1    (clk_x1),
        .rst_n     (rst_n),
        .fb_width  (fb_width),
        .fb_height (fb_height),
        .fb_vsync  (fb_vsync),
        .fb_we     (fb_we),
        .fb_data   (fb_data),
        .video     (video)
    );

    always #20 clk_x1 = ~clk_x1;   // 40 ns period

    //////////////////////////////////////////////////
    // stimulus helpers
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};   // x^8+x^6+x^5+x^4+1
    endfunction

    // one lfsr step per pixel bit
    task automatic random_pixel(output pixel_t p);
        for (int b = 0; b < COLOR_BITS; b++) begin
            lfsr = lfsr_step(lfsr);
            p[b] = lfsr[0];
        end
    endtask

    // vsync pulse, then n_pix pixels in raster order, gap idle cycles between
    task automatic write_frame(input int w, input int h, input int n_pix, input int gap);
        pixel_t p;
        @(posedge clk_x1);
        fb_width  <= 5'(w);
        fb_height <= 4'(h);
        fb_vsync  <= 1'b1;
        @(posedge clk_x1);
        fb_vsync <= 1'b0;
        for (int i = 0; i < n_pix; i++) begin
            random_pixel(p);
            image[i / w][i % w] = p;
            fb_we   <= 1'b1;
            fb_data <= p;
            @(posedge clk_x1);
            if (gap > 0) begin
                fb_we <= 1'b0;
                repeat (gap) @(posedge clk_x1);
            end
        end
        fb_we <= 1'b0;
    endtask

    // floor scaling, then 6-bit channels padded to 8
    function automatic logic [23:0] expected_rgb(input int column, input int row);
        int     sx;
        int     sy;
        pixel_t p;
        sx = column * ref_w / ACTIVE_W;
        sy = row * ref_h / ACTIVE_H;
        p  = image[sy][sx];
        return {p[17:12], 2'b00, p[11:6], 2'b00, p[5:0], 2'b00};
    endfunction

    //////////////////////////////////////////////////
    // waits, each bounded
    task automatic check_next_frame(input int w, input int h);
        int n;
        ref_w    = w;
        ref_h    = h;
        cmp_done = 1'b0;
        cmp_arm  = 1'b1;
        n        = 0;
        while (!cmp_done && n < 3 * FRAME_CYCLES) begin
            @(posedge clk_x1);
            n++;
        end
        if (!cmp_done) begin
            errors++;
            $display("timeout: no complete frame was compared after the write");
        end
    endtask

    task automatic wait_frames(input int n);
        int start;
        int cnt;
        start = frames_seen;
        cnt   = 0;
        while (frames_seen < start + n && cnt < (n + 1) * FRAME_CYCLES) begin
            @(posedge clk_x1);
            cnt++;
        end
        if (frames_seen < start + n) begin
            errors++;
            $display("timeout: fewer than %0d frame starts seen on video.vsync", n);
        end
    endtask

    task automatic wait_for_de();
        int cnt;
        cnt = 0;
        @(negedge clk_x1);
        while (!video.de && cnt < FRAME_CYCLES) begin
            @(negedge clk_x1);
            cnt++;
        end
        if (!video.de) begin
            errors++;
            $display("timeout: video.de never went high");
        end
    endtask

    task automatic begin_test();
        test_no++;
        err_mark = errors;
    endtask

    task automatic report_test(input string name);
        if (errors == err_mark) begin
            passed++;
            $display("test %0d (%s): ok", test_no, name);
        end else begin
            failed++;
            $display("test %0d (%s): %0d errors", test_no, name, errors - err_mark);
        end
    endtask

    //////////////////////////////////////////////////
    // output monitor, samples away from the rising edge
    always @(negedge clk_x1) begin
        if (!rst_n) begin
            col_cnt  = 0;
            line_cnt = 0;
            hs_cnt   = 0;
            vs_cnt   = 0;
            de_prev  = 1'b0;
            vs_prev  = 1'b0;
        end else begin
            if (video.de) begin
                if (video.hsync !== 1'b0 || video.vsync !== 1'b0) begin
                    errors++;
                    $display("Error at %0t ns: video.hsync/vsync in de expected 00 got %b%b",
                             $time, video.hsync, video.vsync);
                end
                if (cmp_active) begin
                    exp_rgb = expected_rgb(col_cnt, line_cnt);
                    frame_pixels++;
                    if (video.rgb !== exp_rgb) begin
                        errors++;
                        if (shown < 10)
                            $display("Error at %0t ns: video.rgb (%0d,%0d) expected %h got %h",
                                     $time, col_cnt, line_cnt, exp_rgb, video.rgb);
                        shown++;
                    end
                end
                col_cnt++;
            end else if (video.rgb !== BLANK_RGB) begin
                errors++;
                $display("Error at %0t ns: video.rgb in blanking expected %h got %h",
                         $time, BLANK_RGB, video.rgb);
            end
            if (de_prev && !video.de) begin   // end of an active line
                if (col_cnt != ACTIVE_W) begin
                    errors++;
                    $display("Error at %0t ns: video.de cycles in line expected %0d got %0d",
                             $time, ACTIVE_W, col_cnt);
                end
                col_cnt = 0;
                line_cnt++;
            end
            if (video.vsync && !vs_prev) begin   // frame boundary
                if (line_cnt != ACTIVE_H) begin
                    errors++;
                    $display("Error at %0t ns: video.de lines in frame expected %0d got %0d",
                             $time, ACTIVE_H, line_cnt);
                end
                if (frames_seen > 0) begin   // a whole frame since the last rise
                    if (hs_cnt != (H_SYNC_END - H_SYNC_START) * V_TOTAL) begin
                        errors++;
                        $display("Error at %0t ns: video.hsync cycles in frame expected %0d got %0d",
                                 $time, (H_SYNC_END - H_SYNC_START) * V_TOTAL, hs_cnt);
                    end
                    if (vs_cnt != (V_SYNC_END - V_SYNC_START) * H_TOTAL) begin
                        errors++;
                        $display("Error at %0t ns: video.vsync cycles in frame expected %0d got %0d",
                                 $time, (V_SYNC_END - V_SYNC_START) * H_TOTAL, vs_cnt);
                    end
                end
                hs_cnt   = 0;
                vs_cnt   = 0;
                line_cnt = 0;
                frames_seen++;
                if (cmp_active) begin
                    if (frame_pixels != ACTIVE_W * ACTIVE_H) begin
                        errors++;
                        $display("Error at %0t ns: compared pixels expected %0d got %0d",
                                 $time, ACTIVE_W * ACTIVE_H, frame_pixels);
                    end
                    cmp_active = 1'b0;
                    cmp_done   = 1'b1;
                end
                if (cmp_arm) begin   // next frame starts after this vsync
                    cmp_arm      = 1'b0;
                    cmp_active   = 1'b1;
                    frame_pixels = 0;
                    shown        = 0;
                end
            end
            if (video.hsync)
                hs_cnt++;
            if (video.vsync)
                vs_cnt++;
            de_prev = video.de;
            vs_prev = video.vsync;
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        clk_x1      = 1'b0;
        rst_n       = 1'b0;
        fb_width    = 5'd16;
        fb_height   = 4'd8;
        fb_vsync    = 1'b0;
        fb_we       = 1'b0;
        fb_data     = '0;
        lfsr        = 8'd35;
        ref_w       = MAX_W;
        ref_h       = MAX_H;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        test_no     = 0;
        frames_seen = 0;
        cmp_arm     = 1'b0;
        cmp_active  = 1'b0;
        cmp_done    = 1'b0;
        repeat (2) @(posedge clk_x1);
        rst_n <= 1'b1;

        // raster shape, syncs quiet out of reset
        begin_test();
        @(negedge clk_x1);
        if (video.de !== 1'b0) begin
            errors++;
            $display("Error at %0t ns: video.de expected 0 got %b", $time, video.de);
        end
        if (video.hsync !== 1'b0) begin
            errors++;
            $display("Error at %0t ns: video.hsync expected 0 got %b", $time, video.hsync);
        end
        if (video.vsync !== 1'b0) begin
            errors++;
            $display("Error at %0t ns: video.vsync expected 0 got %b", $time, video.vsync);
        end
        wait_frames(2);
        report_test("raster timing");

        begin_test();
        write_frame(16, 8, 128, 0);   // back to back pixels
        check_next_frame(16, 8);
        report_test("16x8 at full rate");

        begin_test();
        write_frame(8, 4, 32, 0);
        check_next_frame(8, 4);
        report_test("8x4 scaling");

        // partial quad left behind, must be dropped
        begin_test();
        write_frame(16, 8, 66, 0);
        write_frame(16, 8, 128, 0);
        check_next_frame(16, 8);
        report_test("restart mid frame");

        begin_test();
        wait_for_de();
        write_frame(16, 8, 128, 1);   // during active lines
        check_next_frame(16, 8);
        report_test("write during display");

        $display("%0d tests, %0d ok, %0d with errors, %0d errors in total",
                 test_no, passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- framebuffer_top.f
fb_pkg.sv
video_timing.sv
pixel_packer.sv
line_scaler.sv
mem_arbiter.sv
frame_store.sv
framebuffer_top.sv
framebuffer_assertions.sv
framebuffer_tb.sv

//--- framebuffer_top.sv
`timescale 1ns/1ns

module framebuffer_top (
    input  logic                          clk_x1,
    input  logic                          rst_n,
    input  logic [4:0]                    fb_width,    // multiple of 4
    input  logic [3:0]                    fb_height,
    input  logic                          fb_vsync,
    input  logic                          fb_we,
    input  logic [fb_pkg::COLOR_BITS-1:0] fb_data,
    output fb_pkg::video_out_t            video
);
    import fb_pkg::*;

    video_pos_t pos;
    wr_req_t    wr_req;
    rd_req_t    rd_req;
    rd_rsp_t    rd_rsp;
    mem_cmd_t   mem_cmd;
    logic       wr_grant;
    logic       rd_grant;

    video_timing video_timing_inst (
        .clk_x1 (clk_x1),
        .rst_n  (rst_n),
        .pos    (pos)
    );

    // write side
    pixel_packer pixel_packer_inst (
        .clk_x1   (clk_x1),
        .rst_n    (rst_n),
        .fb_vsync (fb_vsync),
        .fb_we    (fb_we),
        .fb_width (fb_width),
        .fb_data  (fb_data),
        .wr_grant (wr_grant),
        .wr_req   (wr_req)
    );

    // read side and video out
    line_scaler line_scaler_inst (
        .clk_x1    (clk_x1),
        .rst_n     (rst_n),
        .fb_width  (fb_width),
        .fb_height (fb_height),
        .pos       (pos),
        .rd_grant  (rd_grant),
        .rd_rsp    (rd_rsp),
        .rd_req    (rd_req),
        .video     (video)
    );

    mem_arbiter mem_arbiter_inst (
        .clk_x1   (clk_x1),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .rd_req   (rd_req),
        .wr_grant (wr_grant),
        .rd_grant (rd_grant),
        .mem_cmd  (mem_cmd)
    );

    frame_store frame_store_inst (
        .clk_x1  (clk_x1),
        .rst_n   (rst_n),
        .mem_cmd (mem_cmd),
        .rd_rsp  (rd_rsp)
    );

endmodule

//--- line_scaler.sv
`timescale 1ns/1ns

module line_scaler (
    input  logic               clk_x1,
    input  logic               rst_n,
    input  logic [4:0]         fb_width,
    input  logic [3:0]         fb_height,
    input  fb_pkg::video_pos_t pos,
    input  logic               rd_grant,
    input  fb_pkg::rd_rsp_t    rd_rsp,
    output fb_pkg::rd_req_t    rd_req,
    output fb_pkg::video_out_t video
);
    import fb_pkg::*;

    fetch_state_e         state;
    logic [ROW_ACC_W-1:0] row_acc;      // line*fb_height mod ACTIVE_H
    logic [ROW_ACC_W:0]   row_sum;
    logic [ROW_ACC_W-1:0] next_acc;
    logic [ROW_W-1:0]     fetch_row;    // source row in the line buffer
    logic [ROW_W-1:0]     next_row;
    logic [2:0]           n_quads;
    logic [2:0]           issued;       // reads granted this line
    logic [2:0]           landed;       // responses stored
    logic                 req_valid;
    logic [QX_W-1:0]      req_qx;
    pixel_t               line_buf [MAX_W];
    logic [COL_ACC_W-1:0] col_acc;
    logic [COL_ACC_W:0]   col_sum;
    logic [COL_W-1:0]     src_col;
    logic                 s1_de, s1_hs, s1_vs;
    logic [COL_W-1:0]     s1_col;
    logic                 de_q, hs_q, vs_q;
    logic [23:0]          rgb_q;

    // channel expansion, zero LSBs appended
    function automatic logic [23:0] to_rgb(input pixel_t p);
        return {p[3*CH_BITS-1 -: CH_BITS], {(8-CH_BITS){1'b0}},
                p[2*CH_BITS-1 -: CH_BITS], {(8-CH_BITS){1'b0}},
                p[CH_BITS-1 -: CH_BITS],   {(8-CH_BITS){1'b0}}};
    endfunction

    assign n_quads = fb_width[4:2];
    assign row_sum = row_acc + fb_height;

    // source row for display line cy+1
    always_comb begin
        if (pos.cy == CY_W'(V_TOTAL - 1)) begin
            next_acc = '0;   // wraps to line 0
            next_row = '0;
        end else if (row_sum >= (ROW_ACC_W+1)'(ACTIVE_H)) begin
            next_acc = ROW_ACC_W'(row_sum - (ROW_ACC_W+1)'(ACTIVE_H));
            next_row = fetch_row + 1'b1;
        end else begin
            next_acc = row_sum[ROW_ACC_W-1:0];
            next_row = fetch_row;
        end
    end

    //////////////////////////////////////////////////
    // prefetch FSM, runs in horizontal blanking
    always_ff @(posedge clk_x1 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= FETCH_IDLE;
            row_acc   <= '0;
            fetch_row <= '0;
            issued    <= '0;
            landed    <= '0;
            req_valid <= 1'b0;
            req_qx    <= '0;
        end else begin
            if (rd_rsp.valid)
                landed <= landed + 1'b1;
            case (state)
                FETCH_IDLE: if (pos.cx == CX_W'(ACTIVE_W)) begin
                    row_acc   <= next_acc;
                    fetch_row <= next_row;
                    req_qx    <= '0;
                    issued    <= '0;
                    landed    <= '0;
                    if (n_quads != 3'd0) begin
                        req_valid <= 1'b1;
                        state     <= FETCH_ISSUE;
                    end
                end
                FETCH_ISSUE: if (rd_grant) begin
                    issued <= issued + 1'b1;
                    req_qx <= req_qx + 1'b1;      // next quad of the row
                    if (issued + 3'd1 == n_quads) begin
                        req_valid <= 1'b0;
                        state     <= FETCH_DRAIN;
                    end
                end
                FETCH_DRAIN: if (landed == n_quads)
                    state <= FETCH_IDLE;          // all quads in buffer
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    assign rd_req = '{valid: req_valid, addr: {fetch_row, req_qx}};

    // four pixels per response
    always_ff @(posedge clk_x1) begin
        if (rd_rsp.valid) begin
            for (int i = 0; i < 4; i++) begin
                line_buf[{landed[1:0], 2'(i)}] <= rd_rsp.data[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // column accumulator, tracks pos.cx
    assign col_sum = col_acc + fb_width;

    always_ff @(posedge clk_x1 or negedge rst_n) begin
        if (!rst_n) begin
            col_acc <= '0;
            src_col <= '0;
        end else if (pos.cx == CX_W'(H_TOTAL - 1)) begin
            col_acc <= '0;
            src_col <= '0;
        end else if (pos.active) begin
            if (col_sum >= (COL_ACC_W+1)'(ACTIVE_W)) begin
                col_acc <= COL_ACC_W'(col_sum - (COL_ACC_W+1)'(ACTIVE_W));
                src_col <= src_col + 1'b1;
            end else begin
                col_acc <= col_sum[COL_ACC_W-1:0];
            end
        end
    end

    // two stage output, syncs delayed with rgb
    always_ff @(posedge clk_x1 or negedge rst_n) begin
        if (!rst_n) begin
            {s1_de, s1_hs, s1_vs} <= '0;
            {de_q, hs_q, vs_q}    <= '0;
        end else begin
            {s1_de, s1_hs, s1_vs} <= {pos.active, pos.hsync, pos.vsync};
            {de_q, hs_q, vs_q}    <= {s1_de, s1_hs, s1_vs};
        end
    end

    always_ff @(posedge clk_x1) begin
        s1_col <= src_col;
        rgb_q  <= s1_de ? to_rgb(line_buf[s1_col]) : BLANK_RGB;
    end

    assign video = '{rgb: rgb_q, de: de_q, hsync: hs_q, vsync: vs_q};

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input  logic             clk_x1,
    input  logic             rst_n,
    input  fb_pkg::wr_req_t  wr_req,
    input  fb_pkg::rd_req_t  rd_req,
    output logic             wr_grant,
    output logic             rd_grant,
    output fb_pkg::mem_cmd_t mem_cmd
);
    import fb_pkg::*;

    logic              wr_go;   // write served this edge
    logic              rd_go;
    mem_op_e           op_q;
    logic [ADDR_W-1:0] addr_q;
    quad_t             data_q;

    // a request seen with its grant high is already served
    assign wr_go = wr_req.valid && !wr_grant;
    assign rd_go = rd_req.valid && !rd_grant && !wr_go;   // writes first

    //////////////////////////////////////////////////
    // grants and command op, registered together
    always_ff @(posedge clk_x1 or negedge rst_n) begin
        if (!rst_n) begin
            wr_grant <= 1'b0;
            rd_grant <= 1'b0;
            op_q     <= OP_IDLE;
        end else begin
            wr_grant <= wr_go;
            rd_grant <= rd_go;
            if (wr_go)
                op_q <= OP_WRITE;
            else if (rd_go)
                op_q <= OP_READ;
            else
                op_q <= OP_IDLE;
        end
    end

    always_ff @(posedge clk_x1) begin
        addr_q <= wr_go ? wr_req.addr : rd_req.addr;
        data_q <= wr_req.data;   // only used on writes
    end

    assign mem_cmd = '{op: op_q, addr: addr_q, data: data_q};

endmodule

//--- pixel_packer.sv
`timescale 1ns/1ns

module pixel_packer (
    input  logic                          clk_x1,
    input  logic                          rst_n,
    input  logic                          fb_vsync,
    input  logic                          fb_we,
    input  logic [4:0]                    fb_width,
    input  logic [fb_pkg::COLOR_BITS-1:0] fb_data,
    input  logic                          wr_grant,
    output fb_pkg::wr_req_t               wr_req
);
    import fb_pkg::*;

    logic              vsync_r;
    logic              vs_rise;     // start of a new frame
    logic [1:0]        pix_cnt;     // pixels already in acc
    logic [1:0]        slot;        // where this pixel lands
    logic              quad_done;
    pixel_t [2:0]      acc;         // first three pixels of a quad
    logic              req_valid;
    logic [ADDR_W-1:0] req_addr;
    quad_t             req_data;
    logic [4:0]        wr_x;        // pixel column of next quad
    logic [ROW_W-1:0]  wr_y;

    assign vs_rise   = fb_vsync & ~vsync_r;
    assign slot      = vs_rise ? 2'd0 : pix_cnt;   // partial quad dropped on vsync
    assign quad_done = fb_we && (slot == 2'd3);

    //////////////////////////////////////////////////
    // control: pixel count, request level, position
    always_ff @(posedge clk_x1 or negedge rst_n) begin
        if (!rst_n) begin
            vsync_r   <= 1'b0;
            pix_cnt   <= '0;
            req_valid <= 1'b0;
            wr_x      <= '0;
            wr_y      <= '0;
        end else begin
            vsync_r <= fb_vsync;
            if (fb_we)
                pix_cnt <= slot + 1'b1;   // wraps 3 -> 0
            else if (vs_rise)
                pix_cnt <= '0;
            // level held until the arbiter pulses the grant
            if (quad_done)
                req_valid <= 1'b1;
            else if (wr_grant)
                req_valid <= 1'b0;
            if (vs_rise) begin
                wr_x <= '0;
                wr_y <= '0;
            end else if (wr_grant) begin
                if (wr_x + 5'd4 >= fb_width) begin
                    wr_x <= '0;           // next source row
                    wr_y <= wr_y + 1'b1;
                end else begin
                    wr_x <= wr_x + 5'd4;
                end
            end
        end
    end

    // quad assembly and the latched write address
    always_ff @(posedge clk_x1) begin
        if (fb_we) begin
            if (slot == 2'd3) begin
                req_data <= {fb_data, acc[2], acc[1], acc[0]};
                req_addr <= {wr_y, wr_x[QX_W+1:2]};   // y*QUADS_PER_ROW + x/4
            end else begin
                acc[slot] <= fb_data;
            end
        end
    end

    assign wr_req = '{valid: req_valid, addr: req_addr, data: req_data};

endmodule

//--- video_timing.sv
`timescale 1ns/1ns

module video_timing (
    input  logic               clk_x1,
    input  logic               rst_n,
    output fb_pkg::video_pos_t pos
);
    import fb_pkg::*;

    logic [CX_W-1:0] cx;    // 0..H_TOTAL-1
    logic [CY_W-1:0] cy;    // 0..V_TOTAL-1

    //////////////////////////////////////////////////
    // raster counters
    always_ff @(posedge clk_x1 or negedge rst_n) begin
        if (!rst_n) begin
            cx <= '0;
            cy <= '0;
        end else if (cx == CX_W'(H_TOTAL - 1)) begin
            cx <= '0;   // end of line
            if (cy == CY_W'(V_TOTAL - 1))
                cy <= '0;
            else
                cy <= cy + 1'b1;
        end else begin
            cx <= cx + 1'b1;
        end
    end

    // position and syncs straight off the counters
    always_comb begin
        pos.cx     = cx;
        pos.cy     = cy;
        pos.active = (cx < CX_W'(ACTIVE_W)) && (cy < CY_W'(ACTIVE_H));
        // both syncs sit in blanking only
        pos.hsync  = (cx >= CX_W'(H_SYNC_START)) && (cx < CX_W'(H_SYNC_END));
        pos.vsync  = (cy >= CY_W'(V_SYNC_START)) && (cy < CY_W'(V_SYNC_END));
    end

endmodule
